// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // Default datapath width, the modules carry their own parameter
    localparam int WORD_LEN     = 32;
    localparam int REG_ADDR_LEN = 5;   // 32 GPRs

    // Request opcodes from the execute stage
    typedef enum logic [3:0] {
        MEM_OP_NOP = 4'd0,   // Must stay zero, reset state of stage 1
        MEM_OP_ALU = 4'd1,
        MEM_OP_LB  = 4'd2,
        MEM_OP_LBU = 4'd3,
        MEM_OP_LH  = 4'd4,
        MEM_OP_LHU = 4'd5,
        MEM_OP_LW  = 4'd6,
        MEM_OP_SB  = 4'd7,
        MEM_OP_SH  = 4'd8,
        MEM_OP_SW  = 4'd9
    } mem_op_e;

    // Access size code as used by the memory
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd3
    } mem_size_e;

    // Request from execute
    typedef struct packed {
        mem_op_e                 op;
        logic [WORD_LEN-1:0]     addr;
        logic [WORD_LEN-1:0]     wdata;
        logic [WORD_LEN-1:0]     alu_result;
        logic [REG_ADDR_LEN-1:0] rd;
    } mem_req_t;

    // Decoded control, stage 1 to stages 2 and 3
    typedef struct packed {
        logic                    write_en;
        mem_size_e               size;
        logic                    is_unsigned;
        logic                    load;
        logic                    reg_write;
        logic                    misaligned;
        logic [REG_ADDR_LEN-1:0] rd;
        logic [WORD_LEN-1:0]     alu_result;
    } mem_ctrl_t;

    // Writeback bundle towards the register file
    typedef struct packed {
        logic                    reg_write;
        logic [REG_ADDR_LEN-1:0] rd;
        logic [WORD_LEN-1:0]     data;
        logic                    exc;    // Alignment fault
    } wb_t;

endpackage

`default_nettype wire

// ==== mem_access_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_access_unit
    import mem_pkg::*;
#(
    parameter int WORD_LEN = mem_pkg::WORD_LEN
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst,
    input  wire logic                i_step,
    input  wire mem_req_t            i_req,
    output mem_ctrl_t                o_ctrl,
    output logic [WORD_LEN-1:0]      o_addr,
    output logic [WORD_LEN-1:0]      o_wdata
);

    mem_req_t  req_q;        // Captured request
    mem_size_e size;
    logic      is_load;
    logic      is_store;
    logic      is_unsigned;
    logic      alu_write;
    logic      misaligned;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            req_q <= '0;    // Decodes as NOP
        end else if (i_step) begin
            req_q <= i_req;
        end
    end

    // Opcode decode
    always_comb begin
        size        = SIZE_BYTE;
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_unsigned = 1'b0;
        alu_write   = 1'b0;
        case (req_q.op)
            MEM_OP_ALU: begin
                alu_write = 1'b1;   // Result bypasses memory
            end
            MEM_OP_LB: begin
                is_load = 1'b1;
            end
            MEM_OP_LBU: begin
                is_load     = 1'b1;
                is_unsigned = 1'b1;
            end
            MEM_OP_LH: begin
                is_load = 1'b1;
                size    = SIZE_HALF;
            end
            MEM_OP_LHU: begin
                is_load     = 1'b1;
                is_unsigned = 1'b1;
                size        = SIZE_HALF;
            end
            MEM_OP_LW: begin
                is_load = 1'b1;
                size    = SIZE_WORD;
            end
            MEM_OP_SB: begin
                is_store = 1'b1;
            end
            MEM_OP_SH: begin
                is_store = 1'b1;
                size     = SIZE_HALF;
            end
            MEM_OP_SW: begin
                is_store = 1'b1;
                size     = SIZE_WORD;
            end
            default: begin
                size = SIZE_BYTE;   // NOP
            end
        endcase
    end

    // Halfwords on even, words on 4-byte boundaries
    assign misaligned = (is_load | is_store) &&
                        ((size == SIZE_HALF && req_q.addr[0]) ||
                         (size == SIZE_WORD && req_q.addr[1:0] != 2'b00));

    always_comb begin
        o_ctrl.write_en    = is_store & ~misaligned;
        o_ctrl.size        = size;
        o_ctrl.is_unsigned = is_unsigned;
        o_ctrl.load        = is_load & ~misaligned;
        o_ctrl.reg_write   = alu_write | (is_load & ~misaligned);
        o_ctrl.misaligned  = misaligned;
        o_ctrl.rd          = req_q.rd;
        o_ctrl.alu_result  = req_q.alu_result;
    end

    assign o_addr  = req_q.addr;
    assign o_wdata = req_q.wdata;

endmodule

`default_nettype wire

// ==== data_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_memory
    import mem_pkg::*;
#(
    parameter int WORD_LEN      = mem_pkg::WORD_LEN,
    parameter int MEM_CELL_SIZE = 8,
    parameter int DATA_MEM_SIZE = 16    // Power of two
) (
    input  wire logic                     i_clk,
    input  wire logic                     i_rst,
    input  wire logic                     i_step,
    input  wire mem_ctrl_t                i_ctrl,
    input  wire logic [WORD_LEN-1:0]      i_addr,
    input  wire logic [WORD_LEN-1:0]      i_wdata,
    input  wire logic [WORD_LEN-1:0]      i_dbg_addr,
    output logic [WORD_LEN-1:0]           o_rdata,
    output logic [MEM_CELL_SIZE-1:0]      o_dbg_data
);

    localparam int ADDR_BITS = $clog2(DATA_MEM_SIZE);
    localparam int EXT_BYTE  = WORD_LEN - MEM_CELL_SIZE;
    localparam int EXT_HALF  = WORD_LEN - 2 * MEM_CELL_SIZE;

    logic [MEM_CELL_SIZE-1:0] memory [DATA_MEM_SIZE];

    logic [ADDR_BITS-1:0]     idx     [4];   // Byte indices wrap around
    logic [MEM_CELL_SIZE-1:0] rd_byte [4];   // rd_byte[0] is the MSB
    logic                     sign_bit;
    logic [WORD_LEN-1:0]      load_data;

    // Address modulo memory size
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            idx[k]     = i_addr[ADDR_BITS-1:0] + ADDR_BITS'(k);
            rd_byte[k] = memory[idx[k]];
        end
    end

    // Big-endian puts the sign in the first byte for both sizes
    assign sign_bit = rd_byte[0][MEM_CELL_SIZE-1] & ~i_ctrl.is_unsigned;

    always_comb begin
        case (i_ctrl.size)
            SIZE_BYTE: load_data = {{EXT_BYTE{sign_bit}}, rd_byte[0]};
            SIZE_HALF: load_data = {{EXT_HALF{sign_bit}}, rd_byte[0], rd_byte[1]};
            SIZE_WORD: load_data = {rd_byte[0], rd_byte[1], rd_byte[2], rd_byte[3]};
            default:   load_data = '0;
        endcase
    end

    // Big-endian stores put the MSB at the lowest address
    always_ff @(posedge i_clk) begin
        if (!i_rst && i_step && i_ctrl.write_en) begin
            case (i_ctrl.size)
                SIZE_BYTE: begin
                    memory[idx[0]] <= i_wdata[MEM_CELL_SIZE-1:0];
                end
                SIZE_HALF: begin
                    memory[idx[0]] <= i_wdata[2*MEM_CELL_SIZE-1:MEM_CELL_SIZE];
                    memory[idx[1]] <= i_wdata[MEM_CELL_SIZE-1:0];
                end
                SIZE_WORD: begin
                    memory[idx[0]] <= i_wdata[4*MEM_CELL_SIZE-1:3*MEM_CELL_SIZE];
                    memory[idx[1]] <= i_wdata[3*MEM_CELL_SIZE-1:2*MEM_CELL_SIZE];
                    memory[idx[2]] <= i_wdata[2*MEM_CELL_SIZE-1:MEM_CELL_SIZE];
                    memory[idx[3]] <= i_wdata[MEM_CELL_SIZE-1:0];
                end
                default: ;   // Unused size code
            endcase
        end
    end

    // Load data register holds between loads
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_rdata <= '0;
        end else if (i_step && i_ctrl.load) begin
            o_rdata <= load_data;
        end
    end

    // Combinational debug byte read
    assign o_dbg_data = memory[i_dbg_addr[ADDR_BITS-1:0]];

endmodule

`default_nettype wire

// ==== writeback_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module writeback_stage
    import mem_pkg::*;
#(
    parameter int WORD_LEN = mem_pkg::WORD_LEN
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst,
    input  wire logic                i_step,
    input  wire mem_ctrl_t           i_ctrl,
    input  wire logic [WORD_LEN-1:0] i_rdata,
    output wb_t                      o_wb
);

    mem_ctrl_t ctrl_q;    // Same step as the memory read register
    wb_t       wb_next;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ctrl_q <= '0;
            o_wb   <= '0;
        end else if (i_step) begin
            ctrl_q <= i_ctrl;
            o_wb   <= wb_next;
        end
    end

    // Result select
    always_comb begin
        wb_next.reg_write = ctrl_q.reg_write;
        wb_next.rd        = ctrl_q.rd;
        wb_next.exc       = ctrl_q.misaligned;
        if (ctrl_q.load) begin
            wb_next.data = i_rdata;
        end else if (ctrl_q.reg_write) begin
            wb_next.data = ctrl_q.alu_result;   // ALU pass-through
        end else begin
            // Stores, NOPs and faulted accesses
            wb_next.data = '0;
        end
    end

endmodule

`default_nettype wire

// ==== mem_subsystem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem_top
    import mem_pkg::*;
#(
    parameter  int WORD_LEN      = mem_pkg::WORD_LEN,
    parameter  int DATA_MEM_SIZE = 16,
    localparam int MEM_CELL_SIZE = 8
) (
    input  wire logic                     i_clk,
    input  wire logic                     i_rst,
    input  wire logic                     i_step,    // Single-step enable
    input  wire mem_req_t                 i_req,
    input  wire logic [WORD_LEN-1:0]      i_dbg_addr,
    output wb_t                           o_wb,
    output logic [MEM_CELL_SIZE-1:0]      o_dbg_data
);

    mem_ctrl_t           ctrl;
    logic [WORD_LEN-1:0] addr;
    logic [WORD_LEN-1:0] wdata;
    logic [WORD_LEN-1:0] rdata;

    // Stage 1
    mem_access_unit #(
        .WORD_LEN (WORD_LEN)
    ) u_mem_access_unit (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_step  (i_step),
        .i_req   (i_req),
        .o_ctrl  (ctrl),
        .o_addr  (addr),
        .o_wdata (wdata)
    );

    // Stage 2
    data_memory #(
        .WORD_LEN      (WORD_LEN),
        .MEM_CELL_SIZE (MEM_CELL_SIZE),
        .DATA_MEM_SIZE (DATA_MEM_SIZE)
    ) u_data_memory (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_step     (i_step),
        .i_ctrl     (ctrl),
        .i_addr     (addr),
        .i_wdata    (wdata),
        .i_dbg_addr (i_dbg_addr),
        .o_rdata    (rdata),
        .o_dbg_data (o_dbg_data)
    );

    // Stage 3
    writeback_stage #(
        .WORD_LEN (WORD_LEN)
    ) u_writeback_stage (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_step  (i_step),
        .i_ctrl  (ctrl),
        .i_rdata (rdata),
        .o_wb    (o_wb)
    );

endmodule

`default_nettype wire

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsystem
    import mem_pkg::*;
();

    localparam int WORD_LEN      = 32;
    localparam int DATA_MEM_SIZE = 16;
    localparam int CLK_PERIOD    = 4;
    localparam int NUM_DIRECTED  = 12;
    localparam int NUM_RANDOM    = 600;
    localparam int NUM_DRAIN     = 4;
    localparam int NUM_OPS       = 2 * DATA_MEM_SIZE + NUM_DIRECTED + NUM_RANDOM + NUM_DRAIN;

    logic                clk;
    logic                rst;
    logic                step;
    mem_req_t            req;
    logic [WORD_LEN-1:0] dbg_addr;
    wb_t                 wb;
    logic [7:0]          dbg_data;

    integer     seed = 32'h18ca_15e5;
    int         errors = 0;
    int         checks = 0;
    logic [7:0] model_mem [DATA_MEM_SIZE];
    wb_t        exp_pipe  [3];    // [2] is what o_wb should show

    mem_subsystem_top #(
        .WORD_LEN      (WORD_LEN),
        .DATA_MEM_SIZE (DATA_MEM_SIZE)
    ) i_mem_subsystem_top (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_step     (step),
        .i_req      (req),
        .i_dbg_addr (dbg_addr),
        .o_wb       (wb),
        .o_dbg_data (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #((NUM_OPS * 2 + 50) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected time");
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                     $time);
        end
    endtask

    function automatic mem_req_t make_request(input mem_op_e op, input logic [31:0] addr,
                                              input logic [31:0] wdata,
                                              input logic [31:0] alu_result,
                                              input logic [4:0] rd);
        mem_req_t r;
        r.op         = op;
        r.addr       = addr;
        r.wdata      = wdata;
        r.alu_result = alu_result;
        r.rd         = rd;
        return r;
    endfunction

    // Reference model of one request with memory effects applied in order
    task automatic model_request(input mem_req_t r, output wb_t exp);
        int          nbytes;
        int          base;
        logic        is_load;
        logic        is_store;
        logic        sign_ext;
        logic [31:0] value;
        exp      = '0;
        exp.rd   = r.rd;    // rd follows every request
        is_load  = 1'b0;
        is_store = 1'b0;
        sign_ext = 1'b0;
        base     = int'(r.addr % DATA_MEM_SIZE);
        case (r.op)
            MEM_OP_ALU: begin
                exp.reg_write = 1'b1;
                exp.data      = r.alu_result;
            end
            MEM_OP_LB, MEM_OP_LH: begin
                is_load  = 1'b1;
                sign_ext = 1'b1;
            end
            MEM_OP_LBU, MEM_OP_LHU, MEM_OP_LW: is_load = 1'b1;
            MEM_OP_SB, MEM_OP_SH, MEM_OP_SW:   is_store = 1'b1;
            default: ;
        endcase
        // Access width in bytes
        case (r.op)
            MEM_OP_LH, MEM_OP_LHU, MEM_OP_SH: nbytes = 2;
            MEM_OP_LW, MEM_OP_SW:             nbytes = 4;
            default:                          nbytes = 1;
        endcase
        if ((is_load || is_store) && (r.addr % nbytes != 0)) begin
            exp.exc = 1'b1;    // Faulted access writes nothing
        end else if (is_store) begin
            for (int k = 0; k < nbytes; k++)
                model_mem[(base + k) % DATA_MEM_SIZE] = r.wdata[8*(nbytes-1-k) +: 8];
        end else if (is_load) begin
            value = '0;
            for (int k = 0; k < nbytes; k++)
                value = {value[23:0], model_mem[(base + k) % DATA_MEM_SIZE]};
            if (sign_ext && value[8*nbytes-1]) begin
                for (int b = 8 * nbytes; b < 32; b++)
                    value[b] = 1'b1;
            end
            exp.reg_write = 1'b1;
            exp.data      = value;
        end
    endtask

    // Runs from one falling edge to the next
    task automatic run_cycle(input logic do_step, input mem_req_t r);
        wb_t exp_new;
        check_value("o_wb.reg_write", wb.reg_write, exp_pipe[2].reg_write);
        check_value("o_wb.rd", wb.rd, exp_pipe[2].rd);
        check_value("o_wb.data", wb.data, exp_pipe[2].data);
        check_value("o_wb.exc", wb.exc, exp_pipe[2].exc);
        step = do_step;
        req  = r;
        if (do_step) begin
            model_request(r, exp_new);
            exp_pipe[2] = exp_pipe[1];
            exp_pipe[1] = exp_pipe[0];
            exp_pipe[0] = exp_new;
        end
        @(negedge clk);
    endtask

    task automatic random_request(output mem_req_t r);
        int      pick;
        mem_op_e op;
        pick = $unsigned($random(seed)) % 16;
        case (pick)
            0:       op = MEM_OP_NOP;
            1, 2:    op = MEM_OP_ALU;
            3:       op = MEM_OP_LB;
            4:       op = MEM_OP_LBU;
            5:       op = MEM_OP_LH;
            6:       op = MEM_OP_LHU;
            7, 8:    op = MEM_OP_LW;
            9, 10:   op = MEM_OP_SB;
            11, 12:  op = MEM_OP_SH;
            default: op = MEM_OP_SW;
        endcase
        // Up to 3 past the end so some accesses wrap
        r = make_request(op, $unsigned($random(seed)) % (DATA_MEM_SIZE + 4),
                         $random(seed), $random(seed), 5'($random(seed)));
    endtask

    initial begin
        mem_req_t r;
        logic     do_step;
        rst      = 1'b1;
        step     = 1'b0;
        req      = '0;
        dbg_addr = '0;
        for (int i = 0; i < 3; i++)
            exp_pipe[i] = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_value("o_wb", wb, '0);

        // Define every byte before any load
        for (int a = 0; a < DATA_MEM_SIZE; a++)
            run_cycle(1'b1, make_request(MEM_OP_SB, a, $random(seed), 0, 5'(a)));

        // Sign bit set and clear in both bytes and halfwords
        run_cycle(1'b1, make_request(MEM_OP_SW, 0, 32'h807f_7f01, 0, 5'd1));
        run_cycle(1'b1, make_request(MEM_OP_LB, 0, 0, 0, 5'd2));
        run_cycle(1'b1, make_request(MEM_OP_LBU, 0, 0, 0, 5'd3));
        run_cycle(1'b1, make_request(MEM_OP_LB, 1, 0, 0, 5'd4));
        run_cycle(1'b1, make_request(MEM_OP_LH, 0, 0, 0, 5'd5));
        run_cycle(1'b1, make_request(MEM_OP_LHU, 0, 0, 0, 5'd6));
        run_cycle(1'b1, make_request(MEM_OP_LH, 2, 0, 0, 5'd7));
        run_cycle(1'b1, make_request(MEM_OP_SH, 1, 32'h0000_dead, 0, 5'd8));   // Misaligned
        run_cycle(1'b1, make_request(MEM_OP_SW, 2, 32'hdead_beef, 0, 5'd9));   // Misaligned
        run_cycle(1'b0, make_request(MEM_OP_SW, 0, 32'h1234_5678, 0, 5'd10)); // Not stepped
        run_cycle(1'b1, make_request(MEM_OP_LW, 0, 0, 0, 5'd11));
        run_cycle(1'b1, make_request(MEM_OP_ALU, 0, 0, 32'hcafe_f00d, 5'd12));

        for (int n = 0; n < NUM_RANDOM; n++) begin
            do_step = ($random(seed) & 3) != 0;    // About 75 % high
            random_request(r);
            run_cycle(do_step, r);
        end

        // Flush the pipeline and check o_wb once more
        for (int n = 0; n < NUM_DRAIN; n++)
            run_cycle(1'b1, '0);
        run_cycle(1'b0, '0);

        for (int a = 0; a < DATA_MEM_SIZE; a++) begin
            dbg_addr = a;
            @(negedge clk);
            check_value("o_dbg_data", dbg_data, model_mem[a]);
        end

        $display("Run finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
mem_pkg.sv
mem_access_unit.sv
data_memory.sv
writeback_stage.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - mem_pkg.sv
  - mem_access_unit.sv
  - data_memory.sv
  - writeback_stage.sv
  - mem_subsystem_top.sv
  - target: test
    files:
      - tb_mem_subsystem.sv
